//--- build.f
+incdir+tb
rtl/capture_pkg.sv
rtl/wb_pkg.sv
rtl/window_if.sv
rtl/trigger_capture.sv
rtl/record_ram.sv
rtl/window_store.sv
rtl/wb_readout.sv
rtl/adc_capture_top.sv
tb/tb_top.sv

//--- run.sh
#!/bin/sh
# build with verilator, run, then look for the failure line in the log
rm -f sim.log
verilator --binary -Wno-fatal --top-module tb_top -f build.f \
    && { ./obj_dir/Vtb_top > sim.log 2>&1 || true; } \
    && cat sim.log \
    && ! grep -q "TEST FAILED" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

//--- tb/tb_tasks.svh
`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

////////////////////
// compare tasks
////////////////////

task automatic check_word(input string name, input sample_pair_t exp, input sample_pair_t act);
    if (act !== exp)
    begin
        $display("[FAIL] %0t ns %s: expected %h, got %h", $time, name, exp, act);
        abort_run();
    end
endtask

task automatic check_stamp(input string name, input stamp_t exp, input stamp_t act);
    if (act !== exp)
    begin
        $display("[FAIL] %0t ns %s: expected %h, got %h", $time, name, exp, act);
        abort_run();
    end
endtask

task automatic check_dat(input string name, input wb_dat_t exp, input wb_dat_t act);
    if (act !== exp)
    begin
        $display("[FAIL] %0t ns %s: expected %h, got %h", $time, name, exp, act);
        abort_run();
    end
endtask

task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp)
    begin
        $display("[FAIL] %0t ns %s: expected %b, got %b", $time, name, exp, act);
        abort_run();
    end
endtask

////////////////////
// wishbone master
////////////////////

task automatic bus_cycle(input logic we, input wb_adr_t adr, input wb_dat_t wdat,
                         output wb_dat_t rdat);
    bit acked;
    acked = 1'b0;
    @(negedge ADA_DCO);
    wb_cyc = 1'b1;
    wb_stb = 1'b1;
    wb_we = we;
    wb_adr = adr;
    wb_dat_w = wdat;
    for (int i = 0; i < 4 && !acked; i++)
    begin
        @(negedge ADA_DCO);
        acked = wb_ack;                         // data valid together with ack
    end
    rdat = wb_dat_r;
    wb_cyc = 1'b0;                              // end the cycle after ack
    wb_stb = 1'b0;
    wb_we = 1'b0;
    if (!acked)
    begin
        $display("no wishbone ack within 4 cycles for address %h", adr);
        abort_run();
    end
endtask

task automatic wb_read(input wb_adr_t adr, output wb_dat_t rdat);
    bus_cycle(1'b0, adr, '0, rdat);
endtask

task automatic wb_write(input wb_adr_t adr, input wb_dat_t wdat);
    wb_dat_t unused;
    bus_cycle(1'b1, adr, wdat, unused);
endtask

task automatic pop_window();
    wb_write(REG_POP, 32'h0);                   // data value is don't care
endtask

task automatic expect_count(input int n);
    wb_dat_t d;
    wb_read(REG_COUNT, d);
    check_dat("REG_COUNT", wb_dat_t'(n), d);
endtask

////////////////////
// sample stimulus
////////////////////

// b in bits 29:16, a in bits 13:0, rest zero
function automatic sample_pair_t pair_word(input adc_sample_t a, input adc_sample_t b);
    sample_pair_t w;
    w = '0;
    w[13:0] = a;
    w[29:16] = b;
    return w;
endfunction

// -5800 up to 8191, never fires
function automatic adc_sample_t quiet_sample();
    int v;
    v = -TRIG_THRESHOLD + int'($urandom % (8191 + TRIG_THRESHOLD + 1));
    return adc_sample_t'(v);
endfunction

// -5801 down to -8192
function automatic adc_sample_t trigger_sample();
    int v;
    v = -TRIG_THRESHOLD - 1 - int'($urandom % (8192 - TRIG_THRESHOLD));
    return adc_sample_t'(v);
endfunction

task automatic drive_sample(input adc_sample_t a, input adc_sample_t b);
    @(negedge ADA_DCO);
    ada_d = a;
    adb_d = b;
endtask

task automatic idle_cycles(input int n);
    repeat (n) drive_sample('0, '0);
endtask

// pre history, trigger pair, 27 post pairs, 4 idle while history flushes
task automatic fire_window(input adc_sample_t trig_a, input adc_sample_t trig_b);
    adc_sample_t a;
    adc_sample_t b;
    for (int i = 0; i < PRE_LEN; i++)
    begin
        a = quiet_sample();
        b = adc_sample_t'($urandom);
        exp_words[i] = pair_word(a, b);
        drive_sample(a, b);
    end
    drive_sample(trig_a, trig_b);
    exp_stamp = stamp_t'(edge_cnt);             // edges seen before the trigger edge
    exp_words[PRE_LEN] = pair_word(trig_a, trig_b);
    for (int i = PRE_LEN + 1; i < WINDOW_LEN; i++)
    begin
        a = adc_sample_t'($urandom);            // post pairs may hit anything
        b = adc_sample_t'($urandom);
        exp_words[i] = pair_word(a, b);
        drive_sample(a, b);
    end
    idle_cycles(PRE_LEN);
endtask

task automatic check_window(input sample_pair_t words [WINDOW_LEN], input stamp_t stamp);
    wb_dat_t d;
    for (int i = 0; i < WINDOW_LEN; i++)
    begin
        wb_read(WINDOW_BASE + wb_adr_t'(i), d);
        check_word($sformatf("window word %0d", i), words[i], sample_pair_t'(d));
    end
    wb_read(REG_STAMP, d);
    check_stamp("REG_STAMP", stamp, stamp_t'(d));
endtask

`endif

//--- tb/tb_top.sv
`timescale 1ns/1ps

module tb_top;
    import capture_pkg::*;
    import wb_pkg::*;

    localparam int num_windows = 4;
    localparam int max_cycles = 5000;           // well above the full test run

    logic ADA_DCO;
    logic hps_fpga_reset_n;
    adc_sample_t ada_d;
    adc_sample_t adb_d;
    logic wb_cyc;
    logic wb_stb;
    logic wb_we;
    wb_adr_t wb_adr;
    wb_dat_t wb_dat_w;
    wb_dat_t wb_dat_r;
    logic wb_ack;
    logic window_ready;

    int edge_cnt = 0;                           // rising edges since reset release
    int cycle_cnt = 0;
    sample_pair_t exp_words [WINDOW_LEN];       // model of the last fired window
    stamp_t exp_stamp;

    adc_capture_top #(.num_windows(num_windows)) u_dut (
        .ADA_DCO          (ADA_DCO),
        .hps_fpga_reset_n (hps_fpga_reset_n),
        .ada_d            (ada_d),
        .adb_d            (adb_d),
        .wb_cyc           (wb_cyc),
        .wb_stb           (wb_stb),
        .wb_we            (wb_we),
        .wb_adr           (wb_adr),
        .wb_dat_w         (wb_dat_w),
        .wb_dat_r         (wb_dat_r),
        .wb_ack           (wb_ack),
        .window_ready     (window_ready)
    );

    task automatic abort_run();
        $display("TEST FAILED");
        $fatal(1, "run stopped at first error");
    endtask

    `include "tb_tasks.svh"

    ////////////////////
    // clock and counters
    ////////////////////

    initial
    begin
        ADA_DCO = 1'b0;
        forever #50 ADA_DCO = ~ADA_DCO;         // 100 ns period
    end

    always @(posedge ADA_DCO or negedge hps_fpga_reset_n)
    begin
        if (!hps_fpga_reset_n)
            edge_cnt <= 0;
        else
            edge_cnt <= edge_cnt + 1;           // first edge after release reads 0
    end

    always @(posedge ADA_DCO)
    begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt == max_cycles)
        begin
            $display("timeout: tests did not finish within %0d cycles", max_cycles);
            abort_run();
        end
    end

    ////////////////////
    // tests
    ////////////////////

    task automatic test_after_reset();
        wb_dat_t d;
        check_flag("window_ready", 1'b0, window_ready);
        expect_count(0);
        wb_read(WINDOW_BASE, d);
        check_dat("window word 0", EMPTY_WORD, d);  // empty ring sentinel
        wb_read(REG_STAMP, d);
        check_dat("REG_STAMP", EMPTY_WORD, d);
    endtask

    task automatic test_single_window();
        fire_window(trigger_sample(), adc_sample_t'($urandom));
        expect_count(1);
        check_flag("window_ready", 1'b1, window_ready);
        check_window(exp_words, exp_stamp);
        pop_window();
        expect_count(0);
    endtask

    task automatic test_threshold();
        drive_sample(adc_sample_t'(-TRIG_THRESHOLD), '0);  // exactly at threshold
        idle_cycles(40);
        expect_count(0);
        drive_sample('0, adc_sample_t'(-8192));            // deep negative on b only
        idle_cycles(40);
        expect_count(0);
        fire_window(adc_sample_t'(-TRIG_THRESHOLD - 1), adc_sample_t'($urandom));
        expect_count(1);
        check_window(exp_words, exp_stamp);
        pop_window();
        expect_count(0);
    endtask

    task automatic test_fifo_order();
        stamp_t stamps [$];
        sample_pair_t firsts [$];
        wb_dat_t d;
        for (int w = 0; w < 3; w++)
        begin
            fire_window(trigger_sample(), adc_sample_t'($urandom));
            stamps.push_back(exp_stamp);
            firsts.push_back(exp_words[0]);
        end
        for (int w = 0; w < 3; w++)
        begin
            expect_count(3 - w);                // oldest first
            wb_read(REG_STAMP, d);
            check_stamp("REG_STAMP", stamps[w], stamp_t'(d));
            wb_read(WINDOW_BASE, d);
            check_word("window word 0", firsts[w], sample_pair_t'(d));
            pop_window();
        end
        expect_count(0);
        check_flag("window_ready", 1'b0, window_ready);
        wb_read(WINDOW_BASE, d);
        check_dat("window word 0", EMPTY_WORD, d);
        wb_read(REG_STAMP, d);
        check_dat("REG_STAMP", EMPTY_WORD, d);
    endtask

    task automatic test_backpressure();
        stamp_t stamps [$];
        sample_pair_t oldest [WINDOW_LEN];
        wb_dat_t d;
        for (int w = 0; w < num_windows; w++)
        begin
            fire_window(trigger_sample(), adc_sample_t'($urandom));
            stamps.push_back(exp_stamp);
            if (w == 0)
                oldest = exp_words;
        end
        expect_count(num_windows);
        fire_window(trigger_sample(), adc_sample_t'($urandom));    // ring full, ignored
        expect_count(num_windows);
        check_window(oldest, stamps[0]);
        pop_window();
        expect_count(num_windows - 1);
        fire_window(trigger_sample(), adc_sample_t'($urandom));    // lands in freed slot
        stamps.push_back(exp_stamp);
        expect_count(num_windows);
        for (int w = 1; w <= num_windows; w++)
        begin
            wb_read(REG_STAMP, d);
            check_stamp("REG_STAMP", stamps[w], stamp_t'(d));
            pop_window();
        end
        expect_count(0);
    endtask

    ////////////////////
    // sequence
    ////////////////////

    initial
    begin
        void'($urandom(32'h88f0));
        hps_fpga_reset_n = 1'b0;
        ada_d = '0;
        adb_d = '0;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
        wb_adr = '0;
        wb_dat_w = '0;
        repeat (3) @(posedge ADA_DCO);
        @(negedge ADA_DCO);
        hps_fpga_reset_n = 1'b1;                // release away from the rising edge
        test_after_reset();
        test_single_window();
        test_threshold();
        test_fifo_order();
        test_backpressure();
        $display("TEST OK");
        $finish;
    end

endmodule

//--- rtl/adc_capture_top.sv
`timescale 1ns/1ps

module adc_capture_top #(
    parameter int num_windows = 4
) (
    input  logic                     ADA_DCO,
    input  logic                     hps_fpga_reset_n,
    input  capture_pkg::adc_sample_t ada_d,
    input  capture_pkg::adc_sample_t adb_d,
    input  logic                     wb_cyc,
    input  logic                     wb_stb,
    input  logic                     wb_we,
    input  wb_pkg::wb_adr_t          wb_adr,
    input  wb_pkg::wb_dat_t          wb_dat_w,
    output wb_pkg::wb_dat_t          wb_dat_r,
    output logic                     wb_ack,
    output logic                     window_ready
);

    window_wr_if wr_bus ();                                 // capture -> store
    window_rd_if #(.num_windows(num_windows)) rd_bus ();    // store -> readout

    trigger_capture u_capture (
        .ADA_DCO          (ADA_DCO),
        .hps_fpga_reset_n (hps_fpga_reset_n),
        .ada_d            (ada_d),
        .adb_d            (adb_d),
        .wr               (wr_bus.producer)
    );

    window_store #(.num_windows(num_windows)) u_store (
        .ADA_DCO          (ADA_DCO),
        .hps_fpga_reset_n (hps_fpga_reset_n),
        .wr               (wr_bus.store),
        .rd               (rd_bus.store)
    );

    wb_readout #(.num_windows(num_windows)) u_readout (
        .ADA_DCO          (ADA_DCO),
        .hps_fpga_reset_n (hps_fpga_reset_n),
        .wb_cyc           (wb_cyc),
        .wb_stb           (wb_stb),
        .wb_we            (wb_we),
        .wb_adr           (wb_adr),
        .wb_dat_w         (wb_dat_w),
        .wb_dat_r         (wb_dat_r),
        .wb_ack           (wb_ack),
        .window_ready     (window_ready),
        .rd               (rd_bus.reader)
    );

endmodule

//--- rtl/wb_readout.sv
`timescale 1ns/1ps

module wb_readout #(
    parameter int num_windows = 4
) (
    input  logic             ADA_DCO,
    input  logic             hps_fpga_reset_n,
    input  logic             wb_cyc,
    input  logic             wb_stb,
    input  logic             wb_we,
    input  wb_pkg::wb_adr_t  wb_adr,
    input  wb_pkg::wb_dat_t  wb_dat_w,
    output wb_pkg::wb_dat_t  wb_dat_r,
    output logic             wb_ack,
    output logic             window_ready,
    window_rd_if.reader      rd
);
    import wb_pkg::*;
    import capture_pkg::*;

    logic req;                                  // new request, not yet acked
    logic win_hit;                              // address inside window span
    logic empty;
    logic pop_q;

    assign req = wb_cyc && wb_stb && !wb_ack;
    assign win_hit = (wb_adr - WINDOW_BASE) < wb_adr_t'(WINDOW_LEN);
    assign empty = (rd.count == '0);
    assign window_ready = !empty;

    // ram address follows bus address, word ready at ack
    assign rd.rd_offset = word_offset_t'(wb_adr - WINDOW_BASE);
    assign rd.pop = pop_q;

    ////////////////////
    // ack and pop
    ////////////////////

    // pop data value carries no meaning, any write releases
    always_ff @(posedge ADA_DCO or negedge hps_fpga_reset_n)
    begin
        if (!hps_fpga_reset_n)
        begin
            wb_ack <= 1'b0;
            pop_q <= 1'b0;
        end
        else
        begin
            wb_ack <= req;                      // fixed one-cycle latency
            pop_q <= req && wb_we && (wb_adr == REG_POP);
        end
    end

    ////////////////////
    // read mux
    ////////////////////

    always_comb
    begin
        if (win_hit)
            wb_dat_r = empty ? EMPTY_WORD : wb_dat_t'(rd.rd_word);
        else if (wb_adr == REG_STAMP)
            wb_dat_r = empty ? EMPTY_WORD : wb_dat_t'(rd.rd_stamp);   // zero-extended
        else if (wb_adr == REG_COUNT)
            wb_dat_r = wb_dat_t'(rd.count);
        else
            wb_dat_r = '0;                      // unmapped
    end

endmodule

//--- rtl/window_store.sv
`timescale 1ns/1ps

module window_store #(
    parameter int num_windows = 4
) (
    input  logic        ADA_DCO,
    input  logic        hps_fpga_reset_n,
    window_wr_if.store  wr,
    window_rd_if.store  rd
);
    import capture_pkg::*;

    localparam int slot_w = $clog2(num_windows);
    localparam int cnt_w = $clog2(num_windows + 1);
    localparam int word_aw = $clog2(num_windows * WINDOW_LEN);

    logic [slot_w-1:0] wr_slot;                 // slot being filled
    logic [slot_w-1:0] rd_slot;                 // oldest filled slot
    logic [cnt_w-1:0] fill;
    logic do_pop;

    assign do_pop = rd.pop && (fill != '0);     // pop on empty ring is dropped
    assign wr.full = (fill == cnt_w'(num_windows));
    assign rd.count = fill;

    ////////////////////
    // pointers and fill
    ////////////////////

    always_ff @(posedge ADA_DCO or negedge hps_fpga_reset_n)
    begin
        if (!hps_fpga_reset_n)
        begin
            wr_slot <= '0;
            rd_slot <= '0;
            fill <= '0;
        end
        else
        begin
            if (wr.commit)
                wr_slot <= (wr_slot == slot_w'(num_windows - 1)) ? '0 : wr_slot + 1'b1;
            if (do_pop)
                rd_slot <= (rd_slot == slot_w'(num_windows - 1)) ? '0 : rd_slot + 1'b1;
            case ({wr.commit, do_pop})
                2'b10: fill <= fill + 1'b1;
                2'b01: fill <= fill - 1'b1;
                default: fill <= fill;          // both or neither, no change
            endcase
        end
    end

    ////////////////////
    // storage
    ////////////////////

    // word address is {slot, offset}
    record_ram #(
        .entry_t (sample_pair_t),
        .depth   (num_windows * WINDOW_LEN)
    ) u_words (
        .ADA_DCO (ADA_DCO),
        .we      (wr.wr_en),
        .waddr   (word_aw'({wr_slot, wr.wr_offset})),
        .wdata   (wr.wr_word),
        .raddr   (word_aw'({rd_slot, rd.rd_offset})),
        .rdata   (rd.rd_word)
    );

    record_ram #(
        .entry_t (stamp_t),
        .depth   (num_windows)
    ) u_stamps (
        .ADA_DCO (ADA_DCO),
        .we      (wr.commit),                   // one stamp per closed window
        .waddr   (wr_slot),
        .wdata   (wr.stamp),
        .raddr   (rd_slot),
        .rdata   (rd.rd_stamp)
    );

endmodule

//--- rtl/record_ram.sv
`timescale 1ns/1ps

module record_ram #(
    parameter type entry_t = logic [31:0],
    parameter int depth = 128
) (
    input  logic                     ADA_DCO,
    input  logic                     we,
    input  logic [$clog2(depth)-1:0] waddr,
    input  entry_t                   wdata,
    input  logic [$clog2(depth)-1:0] raddr,
    output entry_t                   rdata
);

    entry_t mem [depth];                        // inferred block ram

    // one write port, registered read port
    always_ff @(posedge ADA_DCO)
    begin
        if (we)
            mem[waddr] <= wdata;
        rdata <= mem[raddr];                    // old data on same-address collision
    end

endmodule

//--- rtl/trigger_capture.sv
`timescale 1ns/1ps

module trigger_capture (
    input  logic                    ADA_DCO,
    input  logic                    hps_fpga_reset_n,
    input  capture_pkg::adc_sample_t ada_d,
    input  capture_pkg::adc_sample_t adb_d,
    window_wr_if.producer           wr
);
    import capture_pkg::*;

    typedef enum logic [1:0]
    {
        ST_ARMED,                               // shifting history, watching ch a
        ST_POST,                                // storing post-trigger pairs
        ST_HIST                                 // flushing frozen history
    } phase_t;

    localparam int hist_w = $clog2(PRE_LEN);

    phase_t phase;
    word_offset_t cnt;                          // next offset in post and hist phases
    sample_pair_t hist [PRE_LEN];               // [0] is oldest
    stamp_t sample_cnt;                         // counts every edge after reset
    stamp_t stamp_q;                            // count at trigger edge
    sample_pair_t live_pair;
    logic trig_hit;

    assign live_pair = pack_pair(ada_d, adb_d);

    // only a non-full ring lets the trigger through
    assign trig_hit = (phase == ST_ARMED) && !wr.full
                      && (int'(ada_d) < -TRIG_THRESHOLD);

    assign wr.stamp = stamp_q;

    ////////////////////
    // write sequencing
    ////////////////////

    always_comb
    begin
        wr.wr_en = 1'b0;
        wr.wr_offset = cnt;
        wr.wr_word = live_pair;                 // live sample unless flushing history
        wr.commit = 1'b0;
        case (phase)
            ST_ARMED:
            begin
                wr.wr_en = trig_hit;            // trigger pair lands right after history
                wr.wr_offset = word_offset_t'(PRE_LEN);
            end
            ST_POST:
            begin
                wr.wr_en = 1'b1;
            end
            ST_HIST:
            begin
                wr.wr_en = 1'b1;
                wr.wr_word = hist[cnt[hist_w-1:0]];
                wr.commit = (cnt == word_offset_t'(PRE_LEN - 1));   // last history word
            end
            default:
            begin
                wr.wr_en = 1'b0;
            end
        endcase
    end

    ////////////////////
    // phase and history
    ////////////////////

    always_ff @(posedge ADA_DCO or negedge hps_fpga_reset_n)
    begin
        if (!hps_fpga_reset_n)
        begin
            phase <= ST_ARMED;
            cnt <= '0;
            sample_cnt <= '0;
            for (int i = 0; i < PRE_LEN; i++)
            begin
                hist[i] <= '0;
            end
        end
        else
        begin
            sample_cnt <= sample_cnt + 1'b1;    // free running, wraps
            case (phase)
                ST_ARMED:
                begin
                    if (trig_hit)
                    begin
                        phase <= ST_POST;
                        cnt <= word_offset_t'(PRE_LEN + 1);
                    end
                    else
                    begin
                        for (int i = 0; i < PRE_LEN - 1; i++)
                        begin
                            hist[i] <= hist[i + 1];
                        end
                        hist[PRE_LEN - 1] <= live_pair;     // newest at the top
                    end
                end
                ST_POST:
                begin
                    if (cnt == word_offset_t'(PRE_LEN + POST_LEN - 1))
                    begin
                        phase <= ST_HIST;
                        cnt <= '0;              // history goes to offsets 0..3
                    end
                    else
                    begin
                        cnt <= cnt + 1'b1;
                    end
                end
                ST_HIST:
                begin
                    if (cnt == word_offset_t'(PRE_LEN - 1))
                        phase <= ST_ARMED;      // rearm next edge
                    else
                        cnt <= cnt + 1'b1;
                end
                default:
                begin
                    phase <= ST_ARMED;
                end
            endcase
        end
    end

    // trigger-edge count held until the window commits
    always_ff @(posedge ADA_DCO)
    begin
        if (trig_hit)
            stamp_q <= sample_cnt;
    end

endmodule

//--- rtl/window_if.sv
`timescale 1ns/1ps

////////////////////
// capture -> store
////////////////////

interface window_wr_if;
    import capture_pkg::*;

    logic wr_en;                                // write wr_word this edge
    word_offset_t wr_offset;                    // position inside current slot
    sample_pair_t wr_word;
    logic commit;                               // closes the slot, one cycle
    stamp_t stamp;                              // stored with commit
    logic full;                                 // ring has no free slot

    modport producer (output wr_en, wr_offset, wr_word, commit, stamp, input full);
    modport store (input wr_en, wr_offset, wr_word, commit, stamp, output full);
endinterface

////////////////////
// store -> readout
////////////////////

interface window_rd_if #(
    parameter int num_windows = 4
);
    import capture_pkg::*;

    word_offset_t rd_offset;                    // word of oldest slot to fetch
    logic pop;                                  // release oldest slot
    sample_pair_t rd_word;                      // one cycle after rd_offset
    stamp_t rd_stamp;
    logic [$clog2(num_windows + 1)-1:0] count;  // filled slots

    modport store (input rd_offset, pop, output rd_word, rd_stamp, count);
    modport reader (output rd_offset, pop, input rd_word, rd_stamp, count);
endinterface

//--- rtl/wb_pkg.sv
package wb_pkg;

    ////////////////////
    // bus widths
    ////////////////////

    localparam int WB_ADR_W = 8;                // word address
    localparam int WB_DAT_W = 32;

    typedef logic [WB_ADR_W-1:0] wb_adr_t;
    typedef logic [WB_DAT_W-1:0] wb_dat_t;

    ////////////////////
    // register map
    ////////////////////

    localparam wb_adr_t WINDOW_BASE = 8'h00;    // words 0..31 of oldest window
    localparam wb_adr_t REG_STAMP = 8'h20;      // stamp of oldest window
    localparam wb_adr_t REG_COUNT = 8'h21;      // windows held
    localparam wb_adr_t REG_POP = 8'h22;        // write releases oldest window

    localparam wb_dat_t EMPTY_WORD = '1;        // returned while ring is empty

endpackage

//--- rtl/capture_pkg.sv
package capture_pkg;

    ////////////////////
    // converter samples
    ////////////////////

    typedef logic signed [13:0] adc_sample_t;   // raw 14-bit two's complement
    typedef logic [31:0] sample_pair_t;         // {2'b0, b, 2'b0, a}
    typedef logic [25:0] stamp_t;               // free-running sample count

    ////////////////////
    // window geometry
    ////////////////////

    localparam int PRE_LEN = 4;                 // history pairs ahead of trigger
    localparam int POST_LEN = 28;               // trigger pair plus 27 more
    localparam int WINDOW_LEN = 32;             // words per stored window

    typedef logic [4:0] word_offset_t;          // index within one window

    // channel a fires when strictly below -TRIG_THRESHOLD
    localparam int TRIG_THRESHOLD = 5800;

    // each channel zero-extended into its own 16-bit half
    function automatic sample_pair_t pack_pair(adc_sample_t a, adc_sample_t b);
        return {2'b00, b, 2'b00, a};
    endfunction

endpackage
